/* Makefile */
# Verilator lint and simulation of the dvi sync generator
TOOL  := verilator
TOP   := tb_hires_dvi_sync
FLIST := hires_dvi_sync.f
FLAGS := --binary --timing --assert -j 0
OBJ   := obj_dir
LOG   := sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ) -f $(FLIST)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "FAIL"; exit 1; \
	elif grep -q "TEST PASSED" $(LOG); then echo "PASS"; \
	else echo "FAIL: no result found in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ) $(LOG)

/* hires_dvi_sync.f */
rtl/dvi_pkg.sv
rtl/dvi_timing_regs.sv
rtl/dvi_raster_counter.sv
rtl/dvi_sync_gen.sv
rtl/dvi_line_buffer.sv
rtl/hires_dvi_sync.sv
tb/tb_hires_dvi_sync.sv

/* rtl/dvi_line_buffer.sv */
/*
 * double line buffer of colour indexes
 * source writes one ram while the raster reads the other, swapped per source line
 */
`timescale 1ns/1ps

module dvi_line_buffer (
    input  logic                           clk_dvi,
    input  logic                           rst,
    input  dvi_pkg::h_t                    h_count,
    input  dvi_pkg::h_t                    x_offset,    // per chip read shift
    input  logic                           wr_en,
    input  logic [dvi_pkg::lb_addr_w-1:0]  wr_x,
    input  dvi_pkg::color_t                wr_color,
    input  logic                           line_start,  // source line begins
    output dvi_pkg::color_t                pixel_color
);

    import dvi_pkg::*;

    logic                 active_buf;     // buffer being read, other one written
    logic                 active_buf_d;   // lines up with the ram read latency
    logic [lb_addr_w-1:0] rd_addr;
    color_t               dout [2];       // registered ram outputs

    assign rd_addr = lb_addr_w'(h_count + x_offset);

    // --------------------------------------------------
    // buffer swap
    // --------------------------------------------------
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            active_buf   <= 1'b0;
            active_buf_d <= 1'b0;
        end else begin
            if (line_start)
                active_buf <= ~active_buf;
            active_buf_d <= active_buf;
        end
    end

    // --------------------------------------------------
    // line rams
    // --------------------------------------------------
    for (genvar b = 0; b < 2; b++) begin : g_ram
        color_t ram [lb_depth];

        // buffer b is written while the other one is on screen
        always_ff @(posedge clk_dvi) begin
            if (wr_en && (active_buf != b[0]))
                ram[wr_x] <= wr_color;
            dout[b] <= ram[rd_addr];    // read every cycle, mux picks later
        end
    end

    // --------------------------------------------------
    // output register
    // --------------------------------------------------
    // two cycles after the h count that addressed it
    always_ff @(posedge clk_dvi) begin
        if (!rst)
            pixel_color <= '0;
        else
            pixel_color <= active_buf_d ? dout[1] : dout[0];
    end

endmodule

/* rtl/dvi_pkg.sv */
/*
 * shared widths, types and per-chip raster timing for the dvi sync generator
 * covers 6567R8, 6567R56A and 6569 at the reduced dvi clock
 */
package dvi_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int h_w       = 11;              // horizontal counter
    localparam int v_w       = 10;              // vertical counter
    localparam int color_w   = 4;               // colour index
    localparam int lb_addr_w = 11;              // line buffer address
    localparam int lb_depth  = 2 ** lb_addr_w;  // entries per line ram

    typedef logic [h_w-1:0]     h_t;
    typedef logic [v_w-1:0]     v_t;
    typedef logic [color_w-1:0] color_t;

    // bit 0 set means a pal part
    typedef enum logic [1:0] {
        CHIP_6567R8   = 2'd0,
        CHIP_6569R3   = 2'd1,
        CHIP_6567R56A = 2'd2,
        CHIP_6569R1   = 2'd3
    } chip_e;

    // polarity bit high means active high
    typedef struct packed {
        logic hpolarity;
        logic vpolarity;
        logic csync_en;     // hsync carries composite, vsync held low
    } sync_cfg_t;

    typedef struct packed {
        h_t   h_max;        // last h count of a line
        h_t   x_offset;     // added to h count for the line buffer read
        h_t   hs_sta;
        h_t   hs_end;
        h_t   ha_sta;       // active starts after this
        h_t   ha_end;       // last active column
        v_t   v_max;        // last line of a frame
        v_t   vs_sta;
        v_t   vs_end;
        v_t   va_sta;
        v_t   va_end;
        logic pal;          // vertical blank wraps through line 0
    } dvi_timing_t;

    // --------------------------------------------------
    // per-chip timing at 26.59 / 27.59 MHz
    // --------------------------------------------------
    localparam dvi_timing_t timing_pal = '{
        h_max: 11'd881, x_offset: 11'd98,
        hs_sta: 11'd0, hs_end: 11'd64, ha_sta: 11'd132, ha_end: 11'd852,
        v_max: 10'd623,
        vs_sta: 10'd0, vs_end: 10'd5, va_sta: 10'd10, va_end: 10'd586,
        pal: 1'b1
    };

    localparam dvi_timing_t timing_ntsc_r8 = '{
        h_max: 11'd844, x_offset: 11'd133,
        hs_sta: 11'd0, hs_end: 11'd64, ha_sta: 11'd88, ha_end: 11'd826,
        v_max: 10'd525,
        vs_sta: 10'd28, vs_end: 10'd44, va_sta: 10'd46, va_end: 10'd26,
        pal: 1'b0
    };

    // narrower line than R8, same vertical layout
    localparam dvi_timing_t timing_ntsc_r56a = '{
        h_max: 11'd831, x_offset: 11'd142,
        hs_sta: 11'd0, hs_end: 11'd64, ha_sta: 11'd88, ha_end: 11'd814,
        v_max: 10'd523,
        vs_sta: 10'd28, vs_end: 10'd44, va_sta: 10'd46, va_end: 10'd26,
        pal: 1'b0
    };

    // reset defaults
    localparam chip_e     cfg_reset_chip = CHIP_6567R8;
    localparam sync_cfg_t cfg_reset_sync = '0;  // active low syncs, no csync

endpackage

/* rtl/dvi_raster_counter.sv */
/*
 * output raster h/v counters and the alternating line brightness flag
 */
`timescale 1ns/1ps

module dvi_raster_counter (
    input  logic                 clk_dvi,
    input  logic                 rst,
    input  dvi_pkg::dvi_timing_t timing,
    output dvi_pkg::h_t          h_count,
    output dvi_pkg::v_t          v_count,
    output logic                 half_bright   // flips every output line
);

    import dvi_pkg::*;

    logic h_wrap;   // last column of the line
    logic v_wrap;   // last line of the frame

    // >= so a count left past a shorter new limit still wraps
    assign h_wrap = (h_count >= timing.h_max);
    assign v_wrap = (v_count >= timing.v_max);

    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            h_count     <= '0;
            v_count     <= '0;
            half_bright <= 1'b0;
        end else if (!h_wrap) begin
            h_count <= h_count + 1'b1;
        end else begin
            h_count <= '0;
            if (!v_wrap) begin
                v_count     <= v_count + 1'b1;
                half_bright <= ~half_bright;   // each native line is drawn twice
            end else begin
                v_count     <= '0;             // new frame
                half_bright <= 1'b0;
            end
        end
    end

endmodule

/* rtl/dvi_sync_gen.sv */
/*
 * registered hsync, vsync (or composite sync) and active window
 * decoded from the raster counters and the chip timing
 */
`timescale 1ns/1ps

module dvi_sync_gen (
    input  logic                 clk_dvi,
    input  logic                 rst,
    input  dvi_pkg::dvi_timing_t timing,
    input  dvi_pkg::sync_cfg_t   sync_cfg,
    input  dvi_pkg::h_t          h_count,
    input  dvi_pkg::v_t          v_count,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 active
);

    import dvi_pkg::*;

    logic hs_ah, vs_ah, cs_ah;      // active high sync terms
    logic hs_out, vs_out, cs_out;   // after polarity
    logic h_act;
    logic nt_vblank, pal_vblank;

    // --------------------------------------------------
    // sync windows
    // --------------------------------------------------
    assign hs_ah = (h_count >= timing.hs_sta) && (h_count < timing.hs_end);

    // vsync window runs in raster order from (vs_sta,hs_sta) up to (vs_end,hs_end)
    assign vs_ah = ((v_count > timing.vs_sta) ||
                    (v_count == timing.vs_sta && h_count >= timing.hs_sta)) &&
                   ((v_count < timing.vs_end) ||
                    (v_count == timing.vs_end && h_count < timing.hs_end));

    assign cs_ah = hs_ah | vs_ah;

    assign hs_out = sync_cfg.hpolarity ? hs_ah : ~hs_ah;
    assign vs_out = sync_cfg.vpolarity ? vs_ah : ~vs_ah;
    assign cs_out = sync_cfg.hpolarity ? cs_ah : ~cs_ah;   // csync follows hsync polarity

    // --------------------------------------------------
    // active window
    // --------------------------------------------------
    assign h_act = (h_count > timing.ha_sta) && (h_count <= timing.ha_end);

    // ntsc blank sits mid frame between va_end and va_sta
    assign nt_vblank = ((v_count >= timing.va_end) && (v_count < timing.va_sta)) ||
                       ((v_count == timing.va_sta) && (h_count < timing.ha_sta));

    // pal blank wraps through line 0
    assign pal_vblank = (v_count < timing.va_sta) ||
                        (v_count > timing.va_end) ||
                        ((v_count == timing.va_end) && (h_count >= timing.ha_sta));

    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            hsync  <= 1'b1;     // idle level for the default active low sync
            vsync  <= 1'b1;
            active <= 1'b0;
        end else begin
            hsync  <= sync_cfg.csync_en ? cs_out : hs_out;
            vsync  <= sync_cfg.csync_en ? 1'b0 : vs_out;
            active <= h_act && !(timing.pal ? pal_vblank : nt_vblank);
        end
    end

endmodule

/* rtl/dvi_timing_regs.sv */
/*
 * chip and sync configuration registers
 * with the chip to raster timing lookup
 */
`timescale 1ns/1ps

module dvi_timing_regs (
    input  logic                clk_dvi,
    input  logic                rst,        // sync, active low
    input  logic                cfg_we,     // one cycle load strobe
    input  dvi_pkg::chip_e      cfg_chip,
    input  dvi_pkg::sync_cfg_t  cfg_sync,
    output dvi_pkg::dvi_timing_t timing,
    output dvi_pkg::sync_cfg_t  sync_cfg
);

    import dvi_pkg::*;

    chip_e     chip_q;  // selected timing standard
    sync_cfg_t sync_q;

    // --------------------------------------------------
    // config registers
    // --------------------------------------------------
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            chip_q <= cfg_reset_chip;
            sync_q <= cfg_reset_sync;
        end else if (cfg_we) begin
            chip_q <= cfg_chip;     // counters keep running across a change
            sync_q <= cfg_sync;
        end
    end

    assign sync_cfg = sync_q;

    // --------------------------------------------------
    // chip to timing lookup
    // --------------------------------------------------
    // R1 and R3 share one raster layout
    always_comb begin
        case (chip_q)
            CHIP_6569R1,
            CHIP_6569R3:   timing = timing_pal;
            CHIP_6567R8:   timing = timing_ntsc_r8;
            CHIP_6567R56A: timing = timing_ntsc_r56a;
            default:       timing = timing_ntsc_r8;
        endcase
    end

endmodule

/* rtl/hires_dvi_sync.sv */
/*
 * dvi sync and pixel generator top level
 */
`timescale 1ns/1ps

module hires_dvi_sync (
    input  logic                           clk_dvi,
    input  logic                           rst,
    input  logic                           cfg_we,
    input  dvi_pkg::chip_e                 cfg_chip,
    input  dvi_pkg::sync_cfg_t             cfg_sync,
    input  logic                           wr_en,
    input  logic [dvi_pkg::lb_addr_w-1:0]  wr_x,
    input  dvi_pkg::color_t                wr_color,
    input  logic                           line_start,
    output logic                           hsync,
    output logic                           vsync,
    output logic                           active,
    output dvi_pkg::color_t                pixel_color,
    output logic                           half_bright
);

    import dvi_pkg::*;

    dvi_timing_t timing;    // current chip raster layout
    sync_cfg_t   sync_cfg;
    h_t          h_count;
    v_t          v_count;

    dvi_timing_regs u_regs (
        .clk_dvi  (clk_dvi),
        .rst      (rst),
        .cfg_we   (cfg_we),
        .cfg_chip (cfg_chip),
        .cfg_sync (cfg_sync),
        .timing   (timing),
        .sync_cfg (sync_cfg)
    );

    dvi_raster_counter u_count (
        .clk_dvi     (clk_dvi),
        .rst         (rst),
        .timing      (timing),
        .h_count     (h_count),
        .v_count     (v_count),
        .half_bright (half_bright)
    );

    dvi_sync_gen u_sync (
        .clk_dvi  (clk_dvi),
        .rst      (rst),
        .timing   (timing),
        .sync_cfg (sync_cfg),
        .h_count  (h_count),
        .v_count  (v_count),
        .hsync    (hsync),
        .vsync    (vsync),
        .active   (active)
    );

    dvi_line_buffer u_lbuf (
        .clk_dvi     (clk_dvi),
        .rst         (rst),
        .h_count     (h_count),
        .x_offset    (timing.x_offset),
        .wr_en       (wr_en),
        .wr_x        (wr_x),
        .wr_color    (wr_color),
        .line_start  (line_start),
        .pixel_color (pixel_color)
    );

endmodule

/* tb/tb_hires_dvi_sync.sv */
/*
 * testbench for the dvi sync and pixel generator
 * random config and line buffer traffic checked against a cycle model
 */
`timescale 1ns/1ps

module tb_hires_dvi_sync;

    import dvi_pkg::*;

    logic                 clk_dvi;
    logic                 rst;
    logic                 cfg_we;
    chip_e                cfg_chip;
    sync_cfg_t            cfg_sync;
    logic                 wr_en;
    logic [lb_addr_w-1:0] wr_x;
    color_t               wr_color;
    logic                 line_start;
    logic                 hsync, vsync, active, half_bright;
    color_t               pixel_color;

    // model state, updated on the rising edge
    chip_e       m_chip;
    sync_cfg_t   m_sync;
    dvi_timing_t mt;
    h_t          m_h;
    v_t          m_v;
    logic        m_hb;
    logic        m_buf, m_buf_d;
    color_t      mram [2][lb_depth];
    bit          mok [2][lb_depth];       // entry written since start
    color_t      q_col [2];               // model of the ram output registers
    bit          q_ok [2];
    logic        exp_hs, exp_vs, exp_act;
    color_t      exp_pix;
    bit          exp_pix_ok;
    logic [20:0] pos;                     // {v,h} in raster order
    logic        hs_a, vs_a, cs_a, h_act, vblank;
    logic [lb_addr_w-1:0] rd;
    color_t      nxt_pix;
    bit          nxt_ok;

    bit          check_en;
    int          err_sync, err_act, err_pix, err_other;
    int          pix_checks;

    hires_dvi_sync DUT (.*);

    initial clk_dvi = 1'b0;
    always #2 clk_dvi = ~clk_dvi;   // 4 ns period

    // raster timing per chip, both 6569 codes share one layout
    function automatic dvi_timing_t chip_timing(input chip_e c);
        dvi_timing_t t;
        begin
            if (c[0])   // 6569, R1 and R3
                t = '{h_max: 11'd881, x_offset: 11'd98, hs_sta: 11'd0, hs_end: 11'd64,
                      ha_sta: 11'd132, ha_end: 11'd852, v_max: 10'd623, vs_sta: 10'd0,
                      vs_end: 10'd5, va_sta: 10'd10, va_end: 10'd586, pal: 1'b1};
            else if (c == CHIP_6567R56A)
                t = '{h_max: 11'd831, x_offset: 11'd142, hs_sta: 11'd0, hs_end: 11'd64,
                      ha_sta: 11'd88, ha_end: 11'd814, v_max: 10'd523, vs_sta: 10'd28,
                      vs_end: 10'd44, va_sta: 10'd46, va_end: 10'd26, pal: 1'b0};
            else
                t = '{h_max: 11'd844, x_offset: 11'd133, hs_sta: 11'd0, hs_end: 11'd64,
                      ha_sta: 11'd88, ha_end: 11'd826, v_max: 10'd525, vs_sta: 10'd28,
                      vs_end: 10'd44, va_sta: 10'd46, va_end: 10'd26, pal: 1'b0};
            return t;
        end
    endfunction

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------
    always @(posedge clk_dvi) begin
        mt  = chip_timing(m_chip);
        rd  = lb_addr_w'(m_h + mt.x_offset);
        pos = {m_v, m_h};
        nxt_pix = m_buf_d ? q_col[1] : q_col[0];    // old ram output, before this read
        nxt_ok  = m_buf_d ? q_ok[1] : q_ok[0];
        for (int b = 0; b < 2; b++) begin
            q_col[b] = mram[b][rd];                 // read before write, like the rams
            q_ok[b]  = mok[b][rd];
        end
        if (wr_en) begin
            mram[~m_buf][wr_x] = wr_color;          // write side is the unread buffer
            mok[~m_buf][wr_x]  = 1'b1;
        end
        if (!rst) begin
            m_h = '0;
            m_v = '0;
            m_hb = 1'b0;
            m_buf = 1'b0;
            m_buf_d = 1'b0;
            m_chip = CHIP_6567R8;
            m_sync = sync_cfg_t'(3'b000);
            exp_hs = 1'b1;
            exp_vs = 1'b1;
            exp_act = 1'b0;
            exp_pix = '0;
            exp_pix_ok = 1'b1;
        end else begin
            hs_a = (m_h >= mt.hs_sta) && (m_h < mt.hs_end);
            vs_a = (pos >= {mt.vs_sta, mt.hs_sta}) && (pos < {mt.vs_end, mt.hs_end});
            cs_a = hs_a | vs_a;
            h_act = (m_h > mt.ha_sta) && (m_h <= mt.ha_end);
            if (mt.pal)     // blank wraps through the top of the frame
                vblank = (pos < {mt.va_sta, 11'd0}) || (pos >= {mt.va_end, mt.ha_sta});
            else
                vblank = (pos >= {mt.va_end, 11'd0}) && (pos < {mt.va_sta, mt.ha_sta});
            exp_hs  = (m_sync.csync_en ? cs_a : hs_a) ~^ m_sync.hpolarity;
            exp_vs  = m_sync.csync_en ? 1'b0 : (vs_a ~^ m_sync.vpolarity);
            exp_act = h_act && !vblank;
            exp_pix = nxt_pix;
            exp_pix_ok = nxt_ok;
            m_buf_d = m_buf;
            if (line_start)
                m_buf = ~m_buf;
            if (m_h >= mt.h_max) begin
                m_h = '0;
                if (m_v >= mt.v_max) begin
                    m_v = '0;
                    m_hb = 1'b0;
                end else begin
                    m_v = m_v + 1'b1;
                    m_hb = ~m_hb;
                end
            end else begin
                m_h = m_h + 1'b1;
            end
            if (cfg_we) begin
                m_chip = cfg_chip;
                m_sync = cfg_sync;
            end
        end
    end

    task automatic note_mismatch(input int kind, input string what,
                                 input logic [15:0] got, input logic [15:0] want);
        begin
            case (kind)
                0: err_sync++;
                1: err_act++;
                2: err_pix++;
                default: err_other++;
            endcase
            $display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // --------------------------------------------------
    // per-cycle checks, outputs settled since the rising edge
    // --------------------------------------------------
    always @(negedge clk_dvi) begin
        if (check_en) begin
            assert (hsync === exp_hs) else note_mismatch(0, "hsync", 16'(hsync), 16'(exp_hs));
            assert (vsync === exp_vs) else note_mismatch(0, "vsync", 16'(vsync), 16'(exp_vs));
            assert (half_bright === m_hb)
                else note_mismatch(3, "half_bright", 16'(half_bright), 16'(m_hb));
            assert (active === exp_act)
                else note_mismatch(1, "active", 16'(active), 16'(exp_act));
            if (exp_pix_ok) begin   // only entries the source has written
                pix_checks++;
                assert (pixel_color === exp_pix)
                    else note_mismatch(2, "pixel_color", 16'(pixel_color), 16'(exp_pix));
            end
        end
    end

    task automatic finish_run;
        int total;
        begin
            total = err_sync + err_act + err_pix + err_other;
            $display("errors: sync %0d, active %0d, pixel %0d, other %0d (%0d pixel checks)",
                     err_sync, err_act, err_pix, err_other, pix_checks);
            if (total == 0)
                $display("TEST PASSED");
            else
                $display("TEST FAILED");
            $finish;
        end
    endtask

    // active low hsync at the default config, so look for a falling edge
    task automatic wait_hsync_assert(input int limit, output int cycles, output bit found);
        int   n;
        logic prev;
        begin
            n = 0;
            found = 1'b0;
            prev = hsync;
            while (!found && n < limit) begin
                @(negedge clk_dvi);
                n++;
                found = (prev === 1'b1) && (hsync === 1'b0);
                prev = hsync;
            end
            cycles = n;
            if (!found) begin
                err_other++;
                $display("hsync did not assert within %0d cycles", limit);
            end
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(negedge clk_dvi);
    endtask

    task automatic strobe_cfg(input chip_e c, input sync_cfg_t s);
        begin
            cfg_we = 1'b1;
            cfg_chip = c;
            cfg_sync = s;
            @(negedge clk_dvi);
            cfg_we = 1'b0;
        end
    endtask

    // one full frame of the chip plus some slack for a mid-frame switch
    task automatic run_frame(input chip_e c);
        dvi_timing_t t;
        begin
            t = chip_timing(c);
            run_cycles((int'(t.h_max) + 1) * (int'(t.v_max) + 1) + 2000);
        end
    endtask

    task automatic random_sync(input bit csync, output sync_cfg_t s);
        begin
            s.hpolarity = 1'($urandom);
            s.vpolarity = 1'($urandom);
            s.csync_en  = csync;
        end
    endtask

    // sequential fill covers the whole ram, otherwise random columns
    task automatic write_line(input bit sequential, input int count);
        for (int i = 0; i < count; i++) begin
            wr_en = 1'b1;
            wr_x = sequential ? lb_addr_w'(i) : lb_addr_w'($urandom);
            wr_color = color_t'($urandom);
            @(negedge clk_dvi);
        end
        wr_en = 1'b0;
    endtask

    task automatic pulse_line_start;
        begin
            line_start = 1'b1;
            @(negedge clk_dvi);
            line_start = 1'b0;
        end
    endtask

    // config sweep, composite sync, then line buffer traffic
    task automatic run_config_and_buffer_tests;
        sync_cfg_t s;
        begin
            run_frame(CHIP_6567R8);

            // every chip, random polarity, strobed at a random point
            for (int i = 0; i < 4; i++) begin
                run_cycles(int'($urandom_range(999)));
                random_sync(1'b0, s);
                strobe_cfg(chip_e'(2'(i)), s);
                run_frame(chip_e'(2'(i)));
            end

            // composite sync on an NTSC and a PAL part
            random_sync(1'b1, s);
            strobe_cfg(CHIP_6567R8, s);
            run_frame(CHIP_6567R8);
            random_sync(1'b1, s);
            strobe_cfg(CHIP_6569R3, s);
            run_frame(CHIP_6569R3);

            // line buffer, both rams filled then random lines
            strobe_cfg(CHIP_6567R56A, sync_cfg_t'(3'b000));
            write_line(1'b1, lb_depth);
            pulse_line_start();
            write_line(1'b1, lb_depth);
            pulse_line_start();
            for (int i = 0; i < 8; i++) begin
                write_line(1'b0, 300 + int'($urandom_range(400)));
                pulse_line_start();
                run_cycles(900);
            end

            assert (pix_checks >= 2000) else begin
                err_other++;
                $display("line buffer read-back was checked on only %0d cycles", pix_checks);
            end
        end
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        int period;
        bit seen;
        void'($urandom(26136));
        rst = 1'b0;
        cfg_we = 1'b0;
        cfg_chip = CHIP_6567R8;
        cfg_sync = sync_cfg_t'(3'b000);
        wr_en = 1'b0;
        wr_x = '0;
        wr_color = '0;
        line_start = 1'b0;
        repeat (10) @(negedge clk_dvi);
        rst = 1'b1;
        check_en = 1'b1;

        // default R8 frame and line period
        wait_hsync_assert(2000, period, seen);
        if (seen)
            wait_hsync_assert(2000, period, seen);
        if (seen) begin
            assert (period == 845)
                else note_mismatch(0, "hsync period", 16'(period), 16'd845);
            run_config_and_buffer_tests();
        end
        finish_run();
    end

endmodule
